// ==== rtl/lc3b_types_pkg.sv ====
package lc3b_types_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    // LC-3b encodings, BR is 0000 so the zero word is a never-taken branch
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef struct packed {
        lc3b_opcode  opcode;
        lc3b_reg     dr;
        lc3b_reg     sr1;
        logic        imm;
        logic [4:0]  low5;       // imm5, or sr2 in [2:0]
    } lc3b_alu_fmt;

    typedef struct packed {
        lc3b_opcode  opcode;
        lc3b_reg     dr_sr;      // dr for LDR, sr for STR
        lc3b_reg     base;
        logic [5:0]  offset6;
    } lc3b_mem_fmt;

    typedef struct packed {
        lc3b_opcode  opcode;
        lc3b_nzp     nzp;
        logic [8:0]  offset9;
    } lc3b_br_fmt;

    // one fetched word, read through whichever format the opcode calls for
    typedef union packed {
        lc3b_alu_fmt alu;
        lc3b_mem_fmt mem;
        lc3b_br_fmt  br;
    } lc3b_instr;

    localparam lc3b_word pc_reset = 16'h0000;
    localparam lc3b_word nop_word = 16'h0000;

endpackage : lc3b_types_pkg

// ==== rtl/lc3b_ctrl_pkg.sv ====
package lc3b_ctrl_pkg;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    typedef enum logic {
        alumux_reg,
        alumux_sext5
    } lc3b_alumux;

    typedef enum logic {
        regfilemux_alu,
        regfilemux_mem
    } lc3b_regfilemux;

    // staged from decode down to writeback
    typedef struct packed {
        lc3b_aluop      aluop;
        lc3b_alumux     alumux_sel;
        logic           load_regfile;
        logic           load_cc;
        logic           mem_read;
        logic           mem_write;
        lc3b_regfilemux regfilemux_sel;
        logic           is_br;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_types_pkg::lc3b_word addr;
        logic                     read;
        logic                     write;
        lc3b_types_pkg::lc3b_word wdata;
    } lc3b_mem_req;

endpackage : lc3b_ctrl_pkg

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps

module regfile
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  lc3b_types_pkg::lc3b_word in,
    input  lc3b_types_pkg::lc3b_reg  dest,
    input  lc3b_types_pkg::lc3b_reg  src_a,
    input  lc3b_types_pkg::lc3b_reg  src_b,
    output lc3b_types_pkg::lc3b_word reg_a,
    output lc3b_types_pkg::lc3b_word reg_b
);

lc3b_types_pkg::lc3b_word data [8];

always_ff @(posedge clk)
begin
    if (rst)
    begin
        for (int i = 0; i < 8; i++)
        begin
            data[i] <= '0;
        end
    end
    else if (load)
    begin
        data[dest] <= in;
    end
end

assign reg_a = data[src_a];    // no write-through, software spaces the hazard
assign reg_b = data[src_b];

endmodule : regfile

// ==== rtl/control_rom.sv ====
`timescale 1ns/1ps

module control_rom
(
    input  lc3b_types_pkg::lc3b_opcode      opcode,
    input  logic                            imm_enable,
    output lc3b_ctrl_pkg::lc3b_control_word ctrl
);

always_comb
begin
    ctrl = '0;      // unknown opcodes fall through as a bubble
    case (opcode)
        lc3b_types_pkg::op_add:
        begin
            ctrl.aluop = lc3b_ctrl_pkg::alu_add;
            ctrl.alumux_sel = imm_enable ? lc3b_ctrl_pkg::alumux_sext5
                                         : lc3b_ctrl_pkg::alumux_reg;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
            ctrl.regfilemux_sel = lc3b_ctrl_pkg::regfilemux_alu;
        end
        lc3b_types_pkg::op_and:
        begin
            ctrl.aluop = lc3b_ctrl_pkg::alu_and;
            ctrl.alumux_sel = imm_enable ? lc3b_ctrl_pkg::alumux_sext5
                                         : lc3b_ctrl_pkg::alumux_reg;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
            ctrl.regfilemux_sel = lc3b_ctrl_pkg::regfilemux_alu;
        end
        lc3b_types_pkg::op_not:
        begin
            ctrl.aluop = lc3b_ctrl_pkg::alu_not;   // low bits are all ones, imm ignored
            ctrl.alumux_sel = lc3b_ctrl_pkg::alumux_reg;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
            ctrl.regfilemux_sel = lc3b_ctrl_pkg::regfilemux_alu;
        end
        lc3b_types_pkg::op_ldr:
        begin
            ctrl.aluop = lc3b_ctrl_pkg::alu_pass;
            ctrl.mem_read = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;       // loads set nzp as well
            ctrl.regfilemux_sel = lc3b_ctrl_pkg::regfilemux_mem;
        end
        lc3b_types_pkg::op_str:
        begin
            ctrl.aluop = lc3b_ctrl_pkg::alu_pass;
            ctrl.mem_write = 1'b1;
        end
        lc3b_types_pkg::op_br:
        begin
            ctrl.aluop = lc3b_ctrl_pkg::alu_pass;
            ctrl.is_br = 1'b1;         // nzp of 000 makes this the NOP
        end
        default:
        begin
            ctrl = '0;
        end
    endcase
end

endmodule : control_rom

// ==== rtl/datapath.sv ====
`timescale 1ns/1ps

module datapath
(
    input  logic                            clk,
    input  logic                            rst,
    input  lc3b_ctrl_pkg::lc3b_control_word ctrl,
    input  lc3b_types_pkg::lc3b_word        mem_rdata,
    input  logic                            fetch_stall,
    output lc3b_types_pkg::lc3b_opcode      opcode,
    output logic                            imm_enable,
    output lc3b_ctrl_pkg::lc3b_mem_req      fetch_req,
    output lc3b_ctrl_pkg::lc3b_mem_req      data_req
);

// fetch / decode
lc3b_types_pkg::lc3b_word pc;
lc3b_types_pkg::lc3b_word pc_dec;
lc3b_types_pkg::lc3b_instr ir;
lc3b_types_pkg::lc3b_reg src_a;
lc3b_types_pkg::lc3b_reg src_b;
lc3b_types_pkg::lc3b_word reg_a;
lc3b_types_pkg::lc3b_word reg_b;

// execute
lc3b_ctrl_pkg::lc3b_control_word ctrl_ex;
lc3b_types_pkg::lc3b_instr ir_ex;
lc3b_types_pkg::lc3b_word pc_ex;
lc3b_types_pkg::lc3b_word reg_a_ex;
lc3b_types_pkg::lc3b_word reg_b_ex;
lc3b_types_pkg::lc3b_word sext5;
lc3b_types_pkg::lc3b_word sext6;
lc3b_types_pkg::lc3b_word adj9;
lc3b_types_pkg::lc3b_word alumux_out;
lc3b_types_pkg::lc3b_word alu_out;
lc3b_types_pkg::lc3b_word base;
lc3b_types_pkg::lc3b_word addr;
lc3b_types_pkg::lc3b_word br_target;

// memory
lc3b_ctrl_pkg::lc3b_control_word ctrl_mem;
lc3b_types_pkg::lc3b_word alu_mem;
lc3b_types_pkg::lc3b_word mar_mem;
lc3b_types_pkg::lc3b_word store_mem;
lc3b_types_pkg::lc3b_word target_mem;
lc3b_types_pkg::lc3b_reg dest_mem;
lc3b_types_pkg::lc3b_nzp nzp_mem;
logic branch_taken;

// writeback
lc3b_ctrl_pkg::lc3b_control_word ctrl_wb;
lc3b_types_pkg::lc3b_word alu_wb;
lc3b_types_pkg::lc3b_word mdr_wb;
lc3b_types_pkg::lc3b_reg dest_wb;
lc3b_types_pkg::lc3b_word regfilemux_out;
lc3b_types_pkg::lc3b_nzp gencc;
lc3b_types_pkg::lc3b_nzp cc;

assign opcode = ir.alu.opcode;
assign imm_enable = ir.alu.imm;

// STR reads its source through port a and its base through port b
assign src_a = ctrl.mem_write ? ir.mem.dr_sr : ir.alu.sr1;
assign src_b = ctrl.mem_write ? ir.mem.base : ir.alu.low5[2:0];

regfile regfile_module
(
    .clk(clk),
    .rst(rst),
    .load(ctrl_wb.load_regfile),
    .in(regfilemux_out),
    .dest(dest_wb),
    .src_a(src_a),
    .src_b(src_b),
    .reg_a(reg_a),
    .reg_b(reg_b)
);

assign sext5 = lc3b_types_pkg::lc3b_word'($signed(ir_ex.alu.low5));
assign sext6 = lc3b_types_pkg::lc3b_word'($signed(ir_ex.mem.offset6));
assign adj9 = lc3b_types_pkg::lc3b_word'($signed({ir_ex.br.offset9, 1'b0}));

assign alumux_out = (ctrl_ex.alumux_sel == lc3b_ctrl_pkg::alumux_sext5) ? sext5 : reg_b_ex;

always_comb
begin
    case (ctrl_ex.aluop)
        lc3b_ctrl_pkg::alu_add: alu_out = reg_a_ex + alumux_out;
        lc3b_ctrl_pkg::alu_and: alu_out = reg_a_ex & alumux_out;
        lc3b_ctrl_pkg::alu_not: alu_out = ~reg_a_ex;
        default:                alu_out = alumux_out;
    endcase
end

assign base = ctrl_ex.mem_write ? reg_b_ex : reg_a_ex;
assign addr = base + (sext6 << 1);      // word offset to byte address
assign br_target = pc_ex + adj9;

assign branch_taken = ctrl_mem.is_br && ((cc & nzp_mem) != 3'b000);

assign regfilemux_out = (ctrl_wb.regfilemux_sel == lc3b_ctrl_pkg::regfilemux_mem) ? mdr_wb
                                                                                  : alu_wb;
assign gencc = regfilemux_out[15] ? 3'b100 : ((regfilemux_out == '0) ? 3'b010 : 3'b001);

always_ff @(posedge clk)
begin
    if (rst)
    begin
        pc <= lc3b_types_pkg::pc_reset;
        ir <= lc3b_types_pkg::nop_word;
        ctrl_ex <= '0;
        ctrl_mem <= '0;
        ctrl_wb <= '0;
        cc <= '0;
    end
    else
    begin
        if (branch_taken)
            pc <= target_mem;               // redirect at end of memory stage
        else if (!fetch_stall)
            pc <= pc + 16'd2;
        ir <= fetch_stall ? lc3b_types_pkg::nop_word : mem_rdata;   // bubble on lost bus
        ctrl_ex <= ctrl;
        ctrl_mem <= ctrl_ex;
        ctrl_wb <= ctrl_mem;
        if (ctrl_wb.load_cc)
            cc <= gencc;
    end
end

always_ff @(posedge clk)
begin
    pc_dec <= pc + 16'd2;
    pc_ex <= pc_dec;
    ir_ex <= ir;
    reg_a_ex <= reg_a;
    reg_b_ex <= reg_b;
    alu_mem <= alu_out;
    mar_mem <= addr;
    store_mem <= reg_a_ex;
    target_mem <= br_target;
    dest_mem <= ir_ex.alu.dr;
    nzp_mem <= ir_ex.br.nzp;
    alu_wb <= alu_mem;
    mdr_wb <= mem_rdata;                    // load data taken in memory stage
    dest_wb <= dest_mem;
end

always_comb
begin
    fetch_req.addr = pc;
    fetch_req.read = 1'b1;
    fetch_req.write = 1'b0;
    fetch_req.wdata = '0;
    data_req.addr = mar_mem;
    data_req.read = ctrl_mem.mem_read;
    data_req.write = ctrl_mem.mem_write;
    data_req.wdata = store_mem;
end

endmodule : datapath

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter
(
    input  lc3b_ctrl_pkg::lc3b_mem_req fetch_req,
    input  lc3b_ctrl_pkg::lc3b_mem_req data_req,
    output logic                       fetch_stall,
    output lc3b_types_pkg::lc3b_word   mem_address,
    output logic                       mem_read,
    output logic                       mem_write,
    output lc3b_types_pkg::lc3b_word   mem_wdata,
    output logic [1:0]                 mem_byte_enable
);

logic data_active;
lc3b_ctrl_pkg::lc3b_mem_req grant;

// data side has fixed priority
assign data_active = data_req.read | data_req.write;
assign fetch_stall = data_active;

always_comb
begin
    if (data_active)
        grant = data_req;
    else
        grant = fetch_req;
end

assign mem_address = grant.addr;
assign mem_read = grant.read;
assign mem_write = grant.write;
assign mem_wdata = grant.wdata;
assign mem_byte_enable = 2'b11;     // word accesses only

endmodule : mem_arbiter

// ==== rtl/lc3b_cpu.sv ====
`timescale 1ns/1ps

module lc3b_cpu
(
    input  logic                     clk,
    input  logic                     rst,
    input  lc3b_types_pkg::lc3b_word mem_rdata,
    output lc3b_types_pkg::lc3b_word mem_address,
    output logic                     mem_read,
    output logic                     mem_write,
    output lc3b_types_pkg::lc3b_word mem_wdata,
    output logic [1:0]               mem_byte_enable
);

lc3b_ctrl_pkg::lc3b_control_word ctrl;
lc3b_types_pkg::lc3b_opcode opcode;
logic imm_enable;
lc3b_ctrl_pkg::lc3b_mem_req fetch_req;
lc3b_ctrl_pkg::lc3b_mem_req data_req;
logic fetch_stall;

datapath datapath_module
(
    .clk(clk),
    .rst(rst),
    .ctrl(ctrl),
    .mem_rdata(mem_rdata),          // shared by fetch and load
    .fetch_stall(fetch_stall),
    .opcode(opcode),
    .imm_enable(imm_enable),
    .fetch_req(fetch_req),
    .data_req(data_req)
);

control_rom control_rom_module
(
    .opcode(opcode),
    .imm_enable(imm_enable),
    .ctrl(ctrl)
);

mem_arbiter mem_arbiter_module
(
    .fetch_req(fetch_req),
    .data_req(data_req),
    .fetch_stall(fetch_stall),
    .mem_address(mem_address),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_wdata(mem_wdata),
    .mem_byte_enable(mem_byte_enable)
);

endmodule : lc3b_cpu

// ==== testbench/lc3b_cpu_properties.sv ====
`timescale 1ns/1ps

module lc3b_cpu_properties
(
    input logic                       clk,
    input logic                       rst,
    input lc3b_ctrl_pkg::lc3b_mem_req data_req,
    input logic                       fetch_stall,
    input lc3b_types_pkg::lc3b_word   mem_address,
    input logic                       mem_read,
    input logic                       mem_write
);

// one bus, one direction per cycle
read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(mem_read && mem_write))
    else $error("memory bus drives read and write in the same cycle");

// a data request takes the bus and stalls fetch
data_owns_bus: assert property (@(posedge clk) disable iff (rst)
    (data_req.read || data_req.write) |->
        (fetch_stall && mem_address == data_req.addr && mem_write == data_req.write))
    else $error("data request did not win the memory bus");

// otherwise the bus carries a plain fetch read
fetch_owns_bus: assert property (@(posedge clk) disable iff (rst)
    !(data_req.read || data_req.write) |-> (!fetch_stall && mem_read && !mem_write))
    else $error("idle data side but the bus is not fetching");

no_write_after_reset: assert property (@(posedge clk)
    rst |=> !mem_write)
    else $error("memory write in the cycle after reset");

endmodule : lc3b_cpu_properties

// ==== testbench/lc3b_cpu_tb.sv ====
`timescale 1ns/1ps

module lc3b_cpu_tb;

localparam int arith_cycles = 60;
localparam int addr_cycles = 60;
localparam int branch_cycles = 130;
localparam int share_cycles = 80;
localparam int warm_cycles = 8;
localparam int reset_cycles = 40;
localparam int watchdog_ns = 4 * (arith_cycles + addr_cycles + branch_cycles + share_cycles
                                  + warm_cycles + reset_cycles + 6 * 12 + 100);
localparam logic [3:0] add_op = 4'b0001;
localparam logic [3:0] and_op = 4'b0101;
localparam logic [3:0] not_op = 4'b1001;
localparam logic [3:0] ldr_op = 4'b0110;
localparam logic [3:0] str_op = 4'b0111;

logic clk = 1'b0;
logic rst = 1'b1;
logic load_image = 1'b0;
logic mem_loaded = 1'b0;
lc3b_types_pkg::lc3b_word mem_rdata;
lc3b_types_pkg::lc3b_word mem_address;
lc3b_types_pkg::lc3b_word mem_wdata;
logic mem_read;
logic mem_write;
logic [1:0] mem_byte_enable;
logic [15:0] mem [65536];
logic [15:0] image [65536];     // next program and data, copied in during reset
logic [15:0] prog [$];

lc3b_cpu UUT
(
    .clk(clk),
    .rst(rst),
    .mem_rdata(mem_rdata),
    .mem_address(mem_address),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_wdata(mem_wdata),
    .mem_byte_enable(mem_byte_enable)
);

bind mem_arbiter lc3b_cpu_properties arbiter_checks
(
    .clk(lc3b_cpu_tb.clk),
    .rst(lc3b_cpu_tb.rst),
    .data_req(data_req),
    .fetch_stall(fetch_stall),
    .mem_address(mem_address),
    .mem_read(mem_read),
    .mem_write(mem_write)
);

always #2 clk = ~clk;

assign mem_rdata = mem_loaded ? mem[{1'b0, mem_address[15:1]}] : 16'h0000;   // same-cycle read

always @(posedge clk)
begin
    if (load_image)
    begin
        for (int i = 0; i < 65536; i++)
        begin
            mem[i] <= image[i];
        end
        mem_loaded <= 1'b1;
    end
    else if (mem_write)
    begin
        compare("byte enable on store", {14'd0, mem_byte_enable}, 16'h0003);
        mem[{1'b0, mem_address[15:1]}] <= mem_wdata;
    end
end

function automatic logic [15:0] alu_word(input logic [3:0] op, input int dr, input int sr1,
                                         input int imm, input int low5);
    return {op, 3'(dr), 3'(sr1), 1'(imm), 5'(low5)};
endfunction

function automatic logic [15:0] mem_word(input logic [3:0] op, input int r, input int base,
                                         input int off6);
    return {op, 3'(r), 3'(base), 6'(off6)};
endfunction

function automatic logic [15:0] br_word(input int nzp, input int off9);
    return {4'b0000, 3'(nzp), 9'(off9)};
endfunction

function automatic logic [15:0] extend5(input logic [4:0] v);
    return {{11{v[4]}}, v};
endfunction

// data slots sit at the top of memory, reached from R0 with offsets -32 .. -1
function automatic int slot_index(input int i);
    return 32'h7fe0 + i;
endfunction

task automatic compare(input string what, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
    begin
        $display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        $display(">>> FAIL");
        $fatal(1, "check failed");
    end
endtask

task automatic expect_slot(input string what, input int i, input logic [15:0] exp);
    compare(what, mem[slot_index(i)], exp);
endtask

task automatic clear_image();
    for (int i = 0; i < 65536; i++)
    begin
        image[i] = 16'h0000;
    end
    prog.delete();
endtask

task automatic emit(input logic [15:0] w);
    prog.push_back(w);
endtask

task automatic pad(input int n);
    repeat (n) emit(16'h0000);
endtask

task automatic hold_reset(input bit watch);
    foreach (prog[i])
    begin
        image[i] = prog[i];
    end
    @(negedge clk);
    rst = 1'b1;
    load_image = 1'b1;
    @(negedge clk);
    load_image = 1'b0;
    repeat (9)
    begin
        if (watch)
            compare("mem_write during reset", {15'd0, mem_write}, 16'h0000);
        @(negedge clk);
    end
    if (watch)
        compare("fetch address in reset", mem_address, 16'h0000);
    rst = 1'b0;
endtask

task automatic run_program(input int cycles);
    hold_reset(1'b0);
    repeat (cycles) @(negedge clk);
endtask

task automatic arithmetic_test();
    logic [15:0] a;
    logic [15:0] b;
    logic [4:0] ia;
    logic [4:0] ib;
    a = 16'($urandom());
    b = 16'($urandom());
    ia = 5'($urandom());
    ib = 5'($urandom());
    clear_image();
    image[slot_index(0)] = a;
    image[slot_index(1)] = b;
    emit(mem_word(ldr_op, 1, 0, -32));
    emit(mem_word(ldr_op, 2, 0, -31));
    pad(3);
    emit(alu_word(add_op, 3, 1, 0, 2));
    emit(alu_word(and_op, 4, 1, 0, 2));
    emit(alu_word(not_op, 5, 1, 1, 31));
    emit(alu_word(add_op, 6, 1, 1, ia));
    emit(alu_word(and_op, 7, 2, 1, ib));
    pad(3);
    for (int r = 3; r <= 7; r++)
    begin
        emit(mem_word(str_op, r, 0, r - 1 - 32));   // R3..R7 to slots 2..6
    end
    run_program(arith_cycles);
    expect_slot("ADD register", 2, a + b);
    expect_slot("AND register", 3, a & b);
    expect_slot("NOT", 4, ~a);
    expect_slot("ADD immediate", 5, a + extend5(ia));
    expect_slot("AND immediate", 6, b & extend5(ib));
endtask

task automatic addressing_test();
    logic [15:0] v;
    logic [15:0] w;
    v = 16'($urandom());
    w = 16'($urandom());
    clear_image();
    image[slot_index(0)] = 16'hffe0;   // pointer to slot 16
    image[slot_index(1)] = v;
    image[slot_index(4)] = w;
    emit(mem_word(ldr_op, 1, 0, -32));
    emit(mem_word(ldr_op, 2, 0, -31));
    pad(3);
    emit(mem_word(str_op, 2, 1, 5));
    emit(mem_word(str_op, 2, 1, -7));
    emit(mem_word(ldr_op, 4, 1, 5));
    emit(mem_word(ldr_op, 5, 1, -12));
    pad(3);
    emit(mem_word(str_op, 4, 0, 25 - 32));
    emit(mem_word(str_op, 5, 0, 26 - 32));
    run_program(addr_cycles);
    expect_slot("STR positive offset", 16 + 5, v);
    expect_slot("STR negative offset", 16 - 7, v);
    expect_slot("LDR positive offset", 25, v);
    expect_slot("LDR negative offset", 26, w);
    expect_slot("word below store", 20, 16'h0000);
    expect_slot("word above store", 22, 16'h0000);
endtask

// BRc jumps to the marker store; the fall-through path jumps past it
task automatic branch_case(input int nzp, input int val, input int slot);
    emit(alu_word(add_op, 2, 0, 1, val));
    pad(3);
    emit(br_word(nzp, 7));
    pad(3);
    emit(br_word(3'b111, 4));
    pad(3);
    emit(mem_word(str_op, 7, 0, slot - 32));
endtask

task automatic branch_test();
    clear_image();
    emit(alu_word(add_op, 7, 0, 1, 9));    // marker
    pad(3);
    branch_case(3'b100, -5, 0);
    branch_case(3'b100, 6, 1);
    branch_case(3'b010, 0, 2);
    branch_case(3'b010, -5, 3);
    branch_case(3'b001, 6, 4);
    branch_case(3'b001, 0, 5);
    run_program(branch_cycles);
    expect_slot("BRn on negative", 0, 16'd9);
    expect_slot("BRn on positive", 1, 16'd0);
    expect_slot("BRz on zero", 2, 16'd9);
    expect_slot("BRz on negative", 3, 16'd0);
    expect_slot("BRp on positive", 4, 16'd9);
    expect_slot("BRp on zero", 5, 16'd0);
endtask

task automatic bus_sharing_test();
    logic [4:0] v [7];
    clear_image();
    for (int k = 1; k <= 6; k++)
    begin
        v[k] = 5'($urandom());
        emit(alu_word(add_op, k, 0, 1, v[k]));
    end
    pad(3);
    for (int blk = 0; blk < 4; blk++)
    begin
        for (int j = 0; j < 3; j++)
        begin
            emit(mem_word(str_op, 1 + (blk * 3 + j) % 6, 0, blk * 3 + j - 32));
        end
        emit(alu_word(add_op, 7, 7, 1, 1));     // sequence counter
    end
    pad(3);
    emit(mem_word(str_op, 7, 0, 12 - 32));
    run_program(share_cycles);
    for (int n = 0; n < 12; n++)
    begin
        expect_slot("back-to-back store", n, extend5(v[1 + n % 6]));
    end
    expect_slot("sequence counter", 12, 16'd4);
endtask

task automatic reset_test();
    clear_image();
    emit(alu_word(add_op, 1, 0, 1, 7));
    pad(3);
    for (int k = 0; k < 8; k++)
    begin
        emit(mem_word(str_op, 1, 0, k - 32));
    end
    run_program(warm_cycles);      // stores are in flight when reset hits
    hold_reset(1'b1);
    @(negedge clk);
    compare("second fetch address", mem_address, 16'h0002);
    compare("fetch read strobe", {15'd0, mem_read}, 16'h0001);
    @(negedge clk);
    compare("third fetch address", mem_address, 16'h0004);
    repeat (reset_cycles) @(negedge clk);
    expect_slot("first instruction result", 0, 16'd7);
    expect_slot("last store result", 7, 16'd7);
endtask

initial
begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display(">>> FAIL");
    $fatal(1, "timeout");
end

initial
begin
    void'($urandom(32'hef62));
    arithmetic_test();
    addressing_test();
    branch_test();
    bus_sharing_test();
    reset_test();
    $display(">>> PASS");
    $finish;
end

endmodule : lc3b_cpu_tb

// ==== lc3b_cpu.f ====
rtl/lc3b_types_pkg.sv
rtl/lc3b_ctrl_pkg.sv
rtl/regfile.sv
rtl/control_rom.sv
rtl/datapath.sv
rtl/mem_arbiter.sv
rtl/lc3b_cpu.sv
testbench/lc3b_cpu_properties.sv
testbench/lc3b_cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f lc3b_cpu.f --top-module lc3b_cpu_tb -o lc3b_cpu_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/lc3b_cpu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
